/* rtl/memPkg.sv */
package memPkg;

    // byte address space of the RAM
    localparam int addrWidth = 12;
    localparam int memDepth = 4096;

    localparam int queueDepth = 4;

    localparam logic [addrWidth-1:0] resetPc = '0;

    // access length in bytes, 1, 2 or 4
    typedef logic [2:0] lenT;

    typedef struct packed {
        logic                 isStore;
        lenT                  len;
        logic [addrWidth-1:0] addr;
        logic [31:0]          wdata;
    } dataReqT;

    typedef struct packed {
        logic                 write;
        logic [addrWidth-1:0] addr;
        logic [7:0]           wdata;
    } memBusT;

    typedef struct packed {
        logic [addrWidth-1:0] pc;
        logic [31:0]          inst;
    } instEntryT;

endpackage

/* rtl/byteRam.sv */
module byteRam (
    input  logic           clk,
    input  memPkg::memBusT memBus,
    output logic [7:0]     memRdata
);
    import memPkg::*;

    logic [7:0] mem [memDepth];

    initial begin
        for (int i = 0; i < memDepth; i++) begin
            mem[i] = 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (memBus.write) begin
            mem[memBus.addr] <= memBus.wdata;
        end
    end

    // read returns old data on a same-address write
    always_ff @(posedge clk) begin
        memRdata <= mem[memBus.addr];
    end

endmodule

/* rtl/memCtrl.sv */
module memCtrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ioBufferFull,
    input  logic                         dataEn,
    input  memPkg::dataReqT              dataReq,
    input  logic                         fetchEn,
    input  logic [memPkg::addrWidth-1:0] fetchAddr,
    input  logic [7:0]                   memRdata,
    output logic                         dataDone,
    output logic [31:0]                  dataRdata,
    output logic                         fetchDone,
    output logic [31:0]                  fetchInst,
    output memPkg::memBusT               memBus
);
    import memPkg::*;

    typedef enum logic [1:0] {
        idle,
        readInst,
        readData,
        writeData
    } stateT;

    stateT                state;
    lenT                  stage;
    lenT                  reqLen;
    lenT                  issueStage;
    logic [addrWidth-1:0] baseAddr;
    logic [31:0]          storeData;
    logic [31:0]          collected;
    logic [31:0]          assembled;
    logic                 accept;
    logic                 lastStage;
    logic                 isRead;

    // data port wins over fetch
    assign accept = (state == idle) && !ioBufferFull && (dataEn || fetchEn);

    assign isRead = (state == readInst) || (state == readData);

    // stage == len is the done cycle, no byte issued then
    assign lastStage = (state != idle) && (stage == reqLen) && !ioBufferFull;

    assign dataDone = lastStage && (state != readInst);
    assign fetchDone = lastStage && (state == readInst);

    // while stalled, re-read the previous byte so memRdata keeps it
    assign issueStage = (ioBufferFull && stage != 3'd0) ? stage - 3'd1 : stage;

    always_comb begin
        memBus.write = (state == writeData) && (stage != reqLen) && !ioBufferFull;
        memBus.addr = baseAddr + addrWidth'(issueStage);
        memBus.wdata = storeData[8*stage[1:0] +: 8];
    end

    // byte from the previous stage goes in little-endian
    always_comb begin
        assembled = collected;
        for (int i = 0; i < 4; i++) begin
            if (stage == lenT'(i + 1)) begin
                assembled[8*i +: 8] = memRdata;
            end
        end
    end

    assign dataRdata = assembled;
    assign fetchInst = assembled;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            stage <= '0;
        end else if (accept) begin
            if (dataEn) begin
                state <= dataReq.isStore ? writeData : readData;
            end else begin
                state <= readInst;
            end
            stage <= '0;
        end else if (lastStage) begin
            state <= idle;
            stage <= '0;
        end else if (state != idle && !ioBufferFull) begin
            stage <= stage + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            // cleared so short loads come back zero-extended
            collected <= '0;
            if (dataEn) begin
                baseAddr <= dataReq.addr;
                reqLen <= dataReq.len;
                storeData <= dataReq.wdata;
            end else begin
                baseAddr <= fetchAddr;
                reqLen <= 3'd4;
            end
        end else if (isRead && !ioBufferFull && stage != reqLen) begin
            collected <= assembled;
        end
    end

endmodule

/* rtl/fetchUnit.sv */
module fetchUnit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         redirectEn,
    input  logic [memPkg::addrWidth-1:0] redirectPc,
    input  logic                         fetchDone,
    input  logic [31:0]                  fetchInst,
    input  logic                         full,
    output logic                         fetchEn,
    output logic [memPkg::addrWidth-1:0] fetchAddr,
    output logic                         push,
    output memPkg::instEntryT            pushEntry,
    output logic                         flush
);
    import memPkg::*;

    logic [addrWidth-1:0] pc;
    logic                 running;
    logic                 pending;
    logic                 discard;
    logic                 fresh;
    instEntryT            heldEntry;

    // a result that belongs to the current pc
    assign fresh = fetchDone && !discard && !redirectEn;

    assign fetchEn = running && !full && !pending;
    assign fetchAddr = pc;
    assign flush = redirectEn;

    assign push = (fresh || (pending && !redirectEn)) && !full;

    always_comb begin
        if (pending) begin
            pushEntry = heldEntry;
        end else begin
            pushEntry.pc = pc;
            pushEntry.inst = fetchInst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            pc <= resetPc;
            pending <= 1'b0;
            discard <= 1'b0;
        end else begin
            running <= 1'b1;
            if (redirectEn) begin
                pc <= redirectPc;
                pending <= 1'b0;
                // whatever fetch is outstanding now is stale
                discard <= fetchEn && !fetchDone;
            end else begin
                if (fresh) begin
                    pc <= pc + addrWidth'(4);
                end
                if (fresh && full) begin
                    pending <= 1'b1;
                end else if (pending && !full) begin
                    pending <= 1'b0;
                end
                if (fetchDone) begin
                    discard <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fresh && full) begin
            heldEntry.pc <= pc;
            heldEntry.inst <= fetchInst;
        end
    end

endmodule

/* rtl/instQueue.sv */
module instQueue (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  memPkg::instEntryT pushEntry,
    input  logic              pop,
    input  logic              flush,
    output logic              full,
    output logic              valid,
    output memPkg::instEntryT head
);
    import memPkg::*;

    typedef logic [$clog2(queueDepth)-1:0] ptrT;
    typedef logic [$clog2(queueDepth + 1)-1:0] countT;

    instEntryT entries [queueDepth];
    ptrT       rdPtr;
    ptrT       wrPtr;
    countT     count;
    logic      doPush;
    logic      doPop;

    function automatic ptrT nextPtr(ptrT ptr);
        return (ptr == ptrT'(queueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == countT'(queueDepth));
    assign valid = (count != '0);
    assign head = entries[rdPtr];

    // flush wins over push and pop
    assign doPush = push && !full && !flush;
    assign doPop = pop && valid && !flush;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= pushEntry;
        end
    end

endmodule

/* rtl/memSubsystem.sv */
module memSubsystem (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ioBufferFull,
    input  logic                         dataEn,
    input  memPkg::dataReqT              dataReq,
    input  logic                         redirectEn,
    input  logic [memPkg::addrWidth-1:0] redirectPc,
    input  logic                         instPop,
    output logic                         dataDone,
    output logic [31:0]                  dataRdata,
    output logic                         instValid,
    output memPkg::instEntryT            instHead
);
    import memPkg::*;

    memBusT               memBus;
    logic [7:0]           memRdata;
    logic                 fetchEn;
    logic [addrWidth-1:0] fetchAddr;
    logic                 fetchDone;
    logic [31:0]          fetchInst;
    logic                 push;
    instEntryT            pushEntry;
    logic                 flush;
    logic                 queueFull;

    memCtrl ctrl (
        .clk          (clk),
        .rst          (rst),
        .ioBufferFull (ioBufferFull),
        .dataEn       (dataEn),
        .dataReq      (dataReq),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .memRdata     (memRdata),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .memBus       (memBus)
    );

    byteRam ram (
        .clk      (clk),
        .memBus   (memBus),
        .memRdata (memRdata)
    );

    fetchUnit fetch (
        .clk        (clk),
        .rst        (rst),
        .redirectEn (redirectEn),
        .redirectPc (redirectPc),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .full       (queueFull),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .push       (push),
        .pushEntry  (pushEntry),
        .flush      (flush)
    );

    // consumer side of the queue is outside this block
    instQueue queue (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .pushEntry (pushEntry),
        .pop       (instPop),
        .flush     (flush),
        .full      (queueFull),
        .valid     (instValid),
        .head      (instHead)
    );

endmodule

/* tests/memSubsystemTb.sv */
module memSubsystemTb;
    timeunit 1ns;
    timeprecision 1ps;
    import memPkg::*;

    localparam int waitLimit = 2000;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 ioBufferFull = 1'b0;
    logic                 dataEn;
    dataReqT              dataReq;
    logic                 redirectEn;
    logic [addrWidth-1:0] redirectPc;
    logic                 instPop = 1'b0;
    logic                 dataDone;
    logic [31:0]          dataRdata;
    logic                 instValid;
    instEntryT            instHead;

    logic [7:0]           mirror [memDepth];
    logic [addrWidth-1:0] expPc = resetPc;
    logic                 popGate = 1'b0;
    logic                 stallGate = 1'b0;
    int                   popCount = 0;
    int                   errorCount = 0;
    int                   checkCount = 0;
    int                   testCount = 0;

    memSubsystem dut (
        .clk          (clk),
        .rst          (rst),
        .ioBufferFull (ioBufferFull),
        .dataEn       (dataEn),
        .dataReq      (dataReq),
        .redirectEn   (redirectEn),
        .redirectPc   (redirectPc),
        .instPop      (instPop),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .instValid    (instValid),
        .instHead     (instHead)
    );

    always #20 clk = ~clk;

    // little-endian, zero-extended read of the mirror
    function automatic logic [31:0] refLoad(input logic [addrWidth-1:0] addr, input lenT len);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < int'(len); i++) begin
            value[8*i +: 8] = mirror[addrWidth'(int'(addr) + i)];
        end
        return value;
    endfunction

    function automatic void writeMirror(input logic [addrWidth-1:0] addr, input lenT len,
                                        input logic [31:0] wdata);
        for (int i = 0; i < int'(len); i++) begin
            mirror[addrWidth'(int'(addr) + i)] = wdata[8*i +: 8];
        end
    endfunction

    // consumer pops at random while allowed
    always @(posedge clk) begin
        instPop <= popGate && ($urandom_range(0, 3) != 0);
    end

    always begin
        @(posedge clk);
        if (stallGate && $urandom_range(0, 3) == 0) begin
            ioBufferFull <= 1'b1;
            repeat ($urandom_range(1, 6)) @(posedge clk);
            ioBufferFull <= 1'b0;
        end
    end

    // negedge values are what the DUT samples at the next edge
    always @(negedge clk) begin
        if (!rst && redirectEn) begin
            expPc = redirectPc;
        end else if (!rst && instPop && instValid) begin
            popCount++;
            checkCount += 2;
            assert (instHead.pc == expPc) else begin
                $display("** Error: instHead.pc expected %h, got %h", expPc, instHead.pc);
                errorCount++;
            end
            assert (instHead.inst == refLoad(expPc, 3'd4)) else begin
                $display("** Error: instHead.inst at pc %h expected %h, got %h",
                         expPc, refLoad(expPc, 3'd4), instHead.inst);
                errorCount++;
            end
            expPc = expPc + addrWidth'(4);
        end
    end

    task automatic dataAccess(input logic store, input lenT len, input logic [addrWidth-1:0] addr,
                              input logic [31:0] wdata, input bit timed);
        logic [31:0] expected;
        int          cycles;
        logic        done;
        expected = refLoad(addr, len);
        @(posedge clk);
        dataEn <= 1'b1;
        dataReq.isStore <= store;
        dataReq.len <= len;
        dataReq.addr <= addr;
        dataReq.wdata <= wdata;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            done = dataDone;
        end
        checkCount++;
        assert (done) else begin
            $display("timeout: no dataDone for access at %h", addr);
            errorCount++;
        end
        // first counted cycle is the accept edge
        if (done && timed) begin
            checkCount++;
            assert (cycles - 1 == int'(len) + 1) else begin
                $display("dataDone came %0d cycles after accept, expected %0d",
                         cycles - 1, int'(len) + 1);
                errorCount++;
            end
        end
        if (done && store) begin
            writeMirror(addr, len, wdata);
        end else if (done) begin
            checkCount++;
            assert (dataRdata == expected) else begin
                $display("** Error: dataRdata at %h len %0d expected %h, got %h",
                         addr, len, expected, dataRdata);
                errorCount++;
            end
        end
        @(posedge clk);
        dataEn <= 1'b0;
    endtask

    task automatic randomAccess(input int base, input int span, input bit timed);
        logic                 store;
        lenT                  len;
        logic [addrWidth-1:0] addr;
        store = 1'($urandom_range(0, 1));
        len = lenT'(1 << $urandom_range(0, 2));
        addr = addrWidth'(base + $urandom_range(0, span - 4));
        dataAccess(store, len, addr, $urandom, timed);
    endtask

    task automatic redirectTo(input logic [addrWidth-1:0] pc);
        @(posedge clk);
        redirectEn <= 1'b1;
        redirectPc <= pc;
        @(posedge clk);
        redirectEn <= 1'b0;
    endtask

    task automatic waitPops(input int n);
        int target;
        int cycles;
        target = popCount + n;
        cycles = 0;
        while (popCount < target && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
        end
        checkCount++;
        assert (popCount >= target) else begin
            $display("timeout: only %0d of %0d queue entries popped", n - (target - popCount), n);
            errorCount++;
        end
    endtask

    task automatic waitStallClear();
        int cycles;
        cycles = 0;
        while (ioBufferFull && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        checkCount++;
        assert (!ioBufferFull) else begin
            $display("timeout: stall input never returned low");
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name, input int errsBefore);
        testCount++;
        if (errorCount == errsBefore) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            $display("test %0d %s: %0d errors", testCount, name, errorCount - errsBefore);
        end
    endtask

    initial begin
        int errsBefore;
        void'($urandom(9676));
        for (int i = 0; i < memDepth; i++) begin
            mirror[i] = 8'h00;
        end
        rst = 1'b1;
        dataEn = 1'b0;
        dataReq = '0;
        redirectEn = 1'b0;
        redirectPc = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // queue fills from pc 0, then fetch goes quiet
        repeat (100) @(posedge clk);

        errsBefore = errorCount;
        for (int i = 0; i < 24; i++) begin
            dataAccess(1'b1, lenT'(1 << $urandom_range(0, 2)),
                       addrWidth'(2048 + $urandom_range(0, 60)), $urandom, 1'b1);
        end
        for (int i = 0; i < 24; i++) begin
            dataAccess(1'b0, lenT'(1 << $urandom_range(0, 2)),
                       addrWidth'(2048 + $urandom_range(0, 60)), '0, 1'b1);
        end
        finishTest("store and load round trip", errsBefore);

        errsBefore = errorCount;
        for (int a = 0; a < 64; a += 4) begin
            dataAccess(1'b1, 3'd4, addrWidth'(a), $urandom, 1'b1);
        end
        redirectTo('0);
        popGate <= 1'b1;
        waitPops(16);
        popGate <= 1'b0;
        finishTest("instruction stream", errsBefore);

        errsBefore = errorCount;
        repeat (100) @(posedge clk);
        popGate <= 1'b1;
        waitPops(12);
        finishTest("back-pressure", errsBefore);

        errsBefore = errorCount;
        for (int i = 0; i < 8; i++) begin
            repeat ($urandom_range(0, 25)) @(posedge clk);
            redirectTo(addrWidth'(4 * $urandom_range(0, 15)));
            waitPops(3);
        end
        finishTest("redirect with fetch in flight", errsBefore);

        errsBefore = errorCount;
        redirectTo('0);
        stallGate <= 1'b1;
        for (int i = 0; i < 24; i++) begin
            randomAccess(3072, 64, 1'b0);
        end
        waitPops(6);
        stallGate <= 1'b0;
        waitStallClear();
        // word reads over the whole window catch stray or missing writes
        for (int a = 3072; a < 3136; a += 4) begin
            dataAccess(1'b0, 3'd4, addrWidth'(a), '0, 1'b0);
        end
        finishTest("stall", errsBefore);

        errsBefore = errorCount;
        redirectTo('0);
        for (int i = 0; i < 32; i++) begin
            if (i % 8 == 7) begin
                redirectTo(addrWidth'(4 * $urandom_range(0, 15)));
            end
            randomAccess(2048, 256, 1'b0);
        end
        waitPops(4);
        finishTest("contention", errsBefore);

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
rtl/memPkg.sv
rtl/byteRam.sv
rtl/memCtrl.sv
rtl/fetchUnit.sv
rtl/instQueue.sv
rtl/memSubsystem.sv
tests/memSubsystemTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module memSubsystemTb -f flist.f -o simv
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
